/* sources.f */
hw/ac97_link_pkg.sv
hw/codec_reg_pkg.sv
hw/switch_debounce.sv
hw/volume_control.sv
hw/codec_init_sequencer.sv
hw/ac97_frame_link.sv
hw/audio_codec_top.sv
tests/tb_audio_codec.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the audio codec testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_audio_codec -Mdir obj_dir -f sources.f > build.log 2>&1 \
  && ./obj_dir/Vtb_audio_codec > sim.log 2>&1 \
  || { echo "build or run failed, see build.log and sim.log"; exit 1; }

cat sim.log

grep -qx "test passed" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tests/tb_audio_codec.sv */
`default_nettype none
//////////////////////////////
// audio codec testbench
// volume presses, frame decoding and record capture checks
//////////////////////////////

module tb_audio_codec import ac97_link_pkg::*, codec_reg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_rows = 6;
  localparam int press_half = 40;
  localparam int frames_per_row = 18;
  // first frames of a row may still carry old values
  localparam int first_checked = 2;

  // one stimulus row and the volume it should end on
  typedef struct packed {
    logic [7:0] ups;
    logic [7:0] downs;
    pcm8_t sample;
    pcm_slot_t pattern;
    volume_t exp_volume;
  } stim_row_t;

  logic clock;
  logic reset;
  logic button_up;
  logic button_down;
  logic sdata_in;
  pcm8_t audio_out;
  pcm8_t audio_in;
  volume_t volume;
  logic sample_strobe;
  logic codec_reset_b;
  logic sync;
  logic sdata_out;

  stim_row_t rows [num_rows];
  volume_t model_volume;
  logic [31:0] lfsr;
  int errors;
  int checks;
  // headphone commands seen in the checked frames of a row
  int headphone_frames;
  longint watchdog_ns = 0;

  audio_codec_top #(.debounce_cycles(16)) i_dut (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .audio_out(audio_out),
    .sdata_in(sdata_in),
    .volume(volume),
    .audio_in(audio_in),
    .sample_strobe(sample_strobe),
    .codec_reset_b(codec_reset_b),
    .sync(sync),
    .sdata_out(sdata_out)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // galois form with a right shift
  function automatic logic [31:0] galois_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic int random_bits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = galois_step(lfsr);
    end
    return value;
  endfunction

  // command the sequencer list holds for this address
  function automatic codec_command_t expected_command(input reg_addr_t addr, input volume_t vol);
    codec_command_t cmd;
    volume_t atten;
    atten = volume_max - vol;
    cmd.valid = 1'b1;
    cmd.addr = addr;
    cmd.data = '0;
    case (addr)
      reg_reset_id: cmd.data = '0;
      reg_headphone: cmd.data = {3'b000, atten, 3'b000, atten};
      reg_pcm_out: cmd.data = pcm_out_level;
      reg_rec_select: cmd.data = {5'b00000, source_mic, 5'b00000, source_mic};
      reg_rec_gain: cmd.data = rec_gain_max;
      reg_mic: cmd.data = mic_boost;
      reg_beep: cmd.data = beep_off;
      reg_general: cmd.data = mix_bypass;
      // address not in the list never matches
      default: cmd.valid = 1'b0;
    endcase
    return cmd;
  endfunction

  task automatic check_volume(input volume_t got, input volume_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s volume %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_command(input codec_command_t got, input codec_command_t exp,
                               input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sample(input pcm8_t got, input pcm8_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // 40 cycles high then 40 low
  task automatic press_button(input logic up);
    @(posedge clock);
    #2;
    button_up = up;
    button_down = !up;
    repeat (press_half) @(posedge clock);
    #2;
    button_up = 1'b0;
    button_down = 1'b0;
    repeat (press_half - 1) @(posedge clock);
  endtask

  // stop at the falling edge of bit 0, where sync has just risen
  task automatic align_frame();
    logic prev;
    prev = sync;
    @(negedge clock);
    while (!(sync && !prev)) begin
      prev = sync;
      @(negedge clock);
    end
  endtask

  // samples one frame at falling edges, drives the record slot after rising edges
  task automatic decode_frame(input stim_row_t row, input logic check);
    codec_command_t got;
    pcm_slot_t word;
    logic exp_bit;
    logic known;
    int nb;
    got = '0;
    word = {row.sample, 12'h000};
    for (int b = 0; b < frame_bits; b++) begin
      known = 1'b1;
      exp_bit = 1'b0;
      if (b == 0 || b == 3 || b == 4) begin
        exp_bit = 1'b1;
      end else if (b == 1 || b == 2) begin
        // command valid, sent twice
        exp_bit = 1'b1;
        got.valid = sdata_out;
      end else if (b >= slot1_first && b < slot1_first + 8) begin
        known = 1'b0;
        got.addr = {got.addr[6:0], sdata_out};
      end else if (b >= slot2_first && b < slot2_first + 16) begin
        known = 1'b0;
        got.data = {got.data[14:0], sdata_out};
      end else if (b >= slot3_first && b <= slot4_last) begin
        // both playback slots carry the same word
        exp_bit = word[slot_width - 1 - ((b - slot3_first) % slot_width)];
      end
      if (check) begin
        check_bit(sync, b <= sync_last_bit, $sformatf("sync at bit %0d", b));
        check_bit(sample_strobe, b == frame_bits - 1, $sformatf("strobe at bit %0d", b));
        if (known) begin
          check_bit(sdata_out, exp_bit, $sformatf("sdata_out bit %0d", b));
        end
      end
      @(posedge clock);
      #2;
      nb = (b + 1) % frame_bits;
      if (nb >= slot3_first && nb < slot4_first) begin
        sdata_in = row.pattern[slot_width - 1 - (nb - slot3_first)];
      end else begin
        sdata_in = 1'b0;
      end
      @(negedge clock);
    end
    if (check) begin
      check_command(got, expected_command(got.addr, model_volume), "command");
      if (got.addr == reg_headphone) begin
        headphone_frames++;
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int hold;
    int extra;
    int ups;
    int downs;
    longint press_cycles;
    errors = 0;
    checks = 0;
    headphone_frames = 0;
    lfsr = 32'h304da157;
    model_volume = volume_reset;
    reset = 1'b1;
    button_up = 1'b0;
    button_down = 1'b0;
    audio_out = '0;
    sdata_in = 1'b0;
    // ups, downs, playback sample, record pattern, final volume
    rows[0] = '{8'd2, 8'd0, 8'hA5, 20'hC3A5F, 5'd10};
    rows[1] = '{8'd0, 8'd3, 8'h5A, 20'h3C5A0, 5'd7};
    rows[2] = '{8'd0, 8'd9, 8'h00, 20'hFFFFF, 5'd0};
    rows[3] = '{8'd1, 8'd0, 8'hFF, 20'h00000, 5'd1};
    rows[4] = '{8'd32, 8'd0, 8'h81, 20'h81234, 5'd31};
    rows[5] = '{8'd0, 8'd1, 8'h7E, 20'h7E00F, 5'd30};
    // room for up to 3 extra presses per row
    press_cycles = 0;
    for (int r = 0; r < num_rows; r++) begin
      press_cycles += (rows[r].ups + rows[r].downs + 3) * 2 * press_half;
    end
    watchdog_ns = (8 + codec_reset_cycles + num_rows * 20 * frame_bits + press_cycles
                   + 4 * frame_bits) * 20;

    repeat (8) @(posedge clock);
    #2;
    reset = 1'b0;

    // link stays silent during the codec reset hold
    hold = 0;
    @(negedge clock);
    while (!codec_reset_b && hold <= codec_reset_cycles) begin
      check_bit(sync, 1'b0, "sync during codec reset");
      check_bit(sample_strobe, 1'b0, "strobe during codec reset");
      check_bit(sdata_out, 1'b0, "sdata_out during codec reset");
      hold++;
      @(negedge clock);
    end
    if (hold != codec_reset_cycles) begin
      errors++;
      $display("codec reset was held for %0d cycles instead of %0d", hold, codec_reset_cycles);
    end
    check_bit(sync, 1'b1, "sync at first frame");

    for (int r = 0; r < num_rows; r++) begin
      @(posedge clock);
      #2;
      audio_out = rows[r].sample;
      // extra presses only push further into saturation
      extra = 0;
      if (rows[r].exp_volume == volume_max || rows[r].exp_volume == '0) begin
        extra = random_bits(2);
      end
      ups = rows[r].ups + ((rows[r].exp_volume == volume_max) ? extra : 0);
      downs = rows[r].downs + ((rows[r].exp_volume == '0) ? extra : 0);
      repeat (ups) begin
        press_button(1'b1);
        model_volume = (model_volume == volume_max) ? volume_max : model_volume + 1'b1;
      end
      repeat (downs) begin
        press_button(1'b0);
        model_volume = (model_volume == '0) ? '0 : model_volume - 1'b1;
      end
      if (model_volume != rows[r].exp_volume) begin
        errors++;
        $display("row %0d table expects volume %0d but the model gives %0d",
                 r, rows[r].exp_volume, model_volume);
      end
      @(negedge clock);
      check_volume(volume, model_volume, "after presses");
      align_frame();
      headphone_frames = 0;
      for (int f = 0; f < frames_per_row; f++) begin
        decode_frame(rows[r], f >= first_checked);
        if (f >= first_checked) begin
          check_sample(audio_in, rows[r].pattern[19:12], "audio_in");
        end
      end
      // the checked frames span one full command list, one headphone step in it
      checks++;
      if (headphone_frames != 1) begin
        errors++;
        $display("ERR %0t: row %0d decoded %0d headphone commands, expected 1",
                 $time, r, headphone_frames);
      end
      $display("row %0d: up %0d down %0d volume %0d, %0d errors so far",
               r, ups, downs, volume, errors);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // limit worked out from the table once it is filled
  initial begin
    wait (watchdog_ns > 0);
    #(watchdog_ns);
    $display("timeout: simulation still running after %0d ns", watchdog_ns);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/audio_codec_top.sv */
`default_nettype none
//////////////////////////////
// audio codec control top
// volume buttons, codec setup and the ac97 serial link
//////////////////////////////

module audio_codec_top import ac97_link_pkg::*, codec_reg_pkg::*; #(
  parameter int debounce_cycles = 270000
) (
  input logic clock,
  input logic reset,
  input logic button_up,
  input logic button_down,
  input pcm8_t audio_out,
  input logic sdata_in,
  output volume_t volume,
  output pcm8_t audio_in,
  output logic sample_strobe,
  output logic codec_reset_b,
  output logic sync,
  output logic sdata_out
);

  // current register access toward the link
  codec_command_t command;

  volume_control #(.debounce_cycles(debounce_cycles)) i_volume (
    .clock(clock),
    .reset(reset),
    .button_up(button_up),
    .button_down(button_down),
    .volume(volume)
  );

  // advances on the frame strobe
  codec_init_sequencer i_sequencer (
    .clock(clock),
    .reset(reset),
    .sample_strobe(sample_strobe),
    .volume(volume),
    .command(command)
  );

  ac97_frame_link i_link (
    .clock(clock),
    .reset(reset),
    .command(command),
    .audio_out(audio_out),
    .sdata_in(sdata_in),
    .audio_in(audio_in),
    .sample_strobe(sample_strobe),
    .codec_reset_b(codec_reset_b),
    .sync(sync),
    .sdata_out(sdata_out)
  );

endmodule

`default_nettype wire

/* hw/ac97_frame_link.sv */
`default_nettype none
//////////////////////////////
// ac97 frame link
// codec reset hold, frame timing, slot serializer and record capture
//////////////////////////////

module ac97_frame_link import ac97_link_pkg::*, codec_reg_pkg::*; (
  input logic clock,
  input logic reset,
  input codec_command_t command,
  input pcm8_t audio_out,
  input logic sdata_in,
  output pcm8_t audio_in,
  output logic sample_strobe,
  output logic codec_reset_b,
  output logic sync,
  output logic sdata_out
);

  typedef logic [$clog2(codec_reset_cycles) - 1:0] hold_count_t;

  hold_count_t hold_count;
  frame_count_t bit_count;

  // values sent during the current frame
  codec_command_t cmd_q;
  playback_pair_t pair_q;
  // record slot shift register
  pcm_slot_t rec_shift;

  // serializer helpers
  pcm_slot_t slot_word;
  frame_count_t slot_first;
  logic [4:0] slot_bit;
  logic in_slot;

  //////////////////////////////
  // codec reset and frame timing
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_count <= '0;
      codec_reset_b <= 1'b0;
      bit_count <= '0;
    end else begin
      if (hold_count == hold_count_t'(codec_reset_cycles - 1)) begin
        codec_reset_b <= 1'b1;
      end else begin
        hold_count <= hold_count + 1'b1;
      end
      // frame counter idles at bit 0 until the codec is out of reset
      if (codec_reset_b) begin
        bit_count <= bit_count + 1'b1;
      end
    end
  end

  // sync over the tag slot, only once frames run
  assign sync = codec_reset_b && (bit_count <= frame_count_t'(sync_last_bit));
  // last bit of the frame
  assign sample_strobe = (bit_count == frame_count_t'(frame_bits - 1));

  //////////////////////////////
  // frame data latch and capture
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q <= '0;
      pair_q <= '0;
      audio_in <= '0;
    end else if (sample_strobe) begin
      cmd_q <= command;
      // left justified, same sample on both channels
      pair_q.left <= {audio_out, 12'h000};
      pair_q.right <= {audio_out, 12'h000};
      // record slot finished long before the end of the frame
      audio_in <= rec_shift[slot_width - 1 -: $bits(pcm8_t)];
    end
  end

  // left record slot, msb first
  always_ff @(posedge clock) begin
    if (bit_count inside {[slot3_first:slot4_first - 1]}) begin
      rec_shift <= {rec_shift[slot_width - 2:0], sdata_in};
    end
  end

  //////////////////////////////
  // serializer
  //////////////////////////////

  // pick the slot word and its first bit
  always_comb begin
    in_slot = bit_count inside {[slot1_first:slot4_last]};
    slot_word = pair_q.right;
    slot_first = frame_count_t'(slot4_first);
    if (bit_count < frame_count_t'(slot2_first)) begin
      slot_word = {cmd_q.addr, 12'h000};
      slot_first = frame_count_t'(slot1_first);
    end else if (bit_count < frame_count_t'(slot3_first)) begin
      slot_word = {cmd_q.data, 4'h0};
      slot_first = frame_count_t'(slot2_first);
    end else if (bit_count < frame_count_t'(slot4_first)) begin
      slot_word = pair_q.left;
      slot_first = frame_count_t'(slot3_first);
    end
    // msb goes first
    slot_bit = 5'(slot_width - 1) - 5'(bit_count - slot_first);
  end

  always_comb begin
    sdata_out = 1'b0;
    if (!codec_reset_b) begin
      sdata_out = 1'b0;
    end else if (bit_count <= frame_count_t'(sync_last_bit)) begin
      // tag slot: frame valid, command valid twice, both playback slots valid
      case (bit_count[3:0])
        4'h0, 4'h3, 4'h4: sdata_out = 1'b1;
        4'h1, 4'h2: sdata_out = cmd_q.valid;
        default: sdata_out = 1'b0;
      endcase
    end else if (in_slot) begin
      sdata_out = slot_word[slot_bit];
    end
  end

  // sync rises at bit 0 and stays up for the whole tag slot
  assert property (@(posedge clock) disable iff (reset)
    $rose(sync) |-> (bit_count == '0) ##1 sync [*sync_last_bit] ##1 !sync);

  // no frames while the codec is still held in reset
  assert property (@(posedge clock) disable iff (reset)
    !codec_reset_b |-> !sample_strobe);

endmodule

`default_nettype wire

/* hw/codec_init_sequencer.sv */
`default_nettype none
//////////////////////////////
// codec setup sequencer
// cycles through the register command list, one step per frame
//////////////////////////////

module codec_init_sequencer import codec_reg_pkg::*; (
  input logic clock,
  input logic reset,
  input logic sample_strobe,
  input volume_t volume,
  output codec_command_t command
);

  typedef logic [$clog2(sequence_steps) - 1:0] step_t;

  step_t step;
  // headphone field is attenuation, not gain
  volume_t atten;
  reg_addr_t next_addr;
  reg_data_t next_data;

  assign atten = volume_max - volume;

  // command word for the current step
  always_comb begin
    next_addr = reg_reset_id;
    next_data = '0;
    case (step)
      4'h3: begin
        // same attenuation on left and right
        next_addr = reg_headphone;
        next_data = {3'b000, atten, 3'b000, atten};
      end
      4'h5: begin
        next_addr = reg_pcm_out;
        next_data = pcm_out_level;
      end
      4'h6: begin
        // record source is fixed to the mic
        next_addr = reg_rec_select;
        next_data = {5'b00000, source_mic, 5'b00000, source_mic};
      end
      4'h7: begin
        next_addr = reg_rec_gain;
        next_data = rec_gain_max;
      end
      4'h9: begin
        next_addr = reg_mic;
        next_data = mic_boost;
      end
      4'hA: begin
        next_addr = reg_beep;
        next_data = beep_off;
      end
      4'hB: begin
        next_addr = reg_general;
        next_data = mix_bypass;
      end
      // steps 0, 1 and the gaps read the vendor id
      default: begin
        next_addr = reg_reset_id;
        next_data = '0;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step <= '0;
      command <= '0;
    end else begin
      // link takes the command on the strobe, so move on then
      if (sample_strobe) begin
        if (step == step_t'(sequence_steps - 1)) begin
          step <= '0;
        end else begin
          step <= step + 1'b1;
        end
      end
      command.valid <= 1'b1;
      command.addr <= next_addr;
      command.data <= next_data;
    end
  end

endmodule

`default_nettype wire

/* hw/volume_control.sv */
`default_nettype none
//////////////////////////////
// volume control
// two debounced buttons step a saturating volume
//////////////////////////////

module volume_control import codec_reg_pkg::*; #(
  parameter int debounce_cycles = 270000
) (
  input logic clock,
  input logic reset,
  input logic button_up,
  input logic button_down,
  output volume_t volume
);

  logic clean_up;
  logic clean_down;
  // delayed clean levels for edge detect
  logic clean_up_d;
  logic clean_down_d;
  logic press_up;
  logic press_down;

  switch_debounce #(.debounce_cycles(debounce_cycles)) i_debounce_up (
    .clock(clock),
    .reset(reset),
    .noisy(button_up),
    .clean(clean_up)
  );

  switch_debounce #(.debounce_cycles(debounce_cycles)) i_debounce_down (
    .clock(clock),
    .reset(reset),
    .noisy(button_down),
    .clean(clean_down)
  );

  // one pulse per clean press
  assign press_up = clean_up & ~clean_up_d;
  assign press_down = clean_down & ~clean_down_d;

  always_ff @(posedge clock) begin
    if (reset) begin
      clean_up_d <= 1'b0;
      clean_down_d <= 1'b0;
      volume <= volume_reset;
    end else begin
      clean_up_d <= clean_up;
      clean_down_d <= clean_down;
      // down wins when both land in the same cycle
      if (press_down && volume != '0) begin
        volume <= volume - 1'b1;
      end else if (press_up && volume != volume_max) begin
        volume <= volume + 1'b1;
      end
    end
  end

  // saturation means no wrap, so one step at most per cycle
  assert property (@(posedge clock) disable iff (reset)
    volume == $past(volume) || volume == $past(volume) + 1 ||
    volume == $past(volume) - 1);

endmodule

`default_nettype wire

/* hw/switch_debounce.sv */
`default_nettype none
//////////////////////////////
// switch debounce
// passes a level on once it has been stable long enough
//////////////////////////////

module switch_debounce #(
  parameter int debounce_cycles = 270000
) (
  input logic clock,
  input logic reset,
  input logic noisy,
  output logic clean
);

  // counter wide enough to reach debounce_cycles
  typedef logic [$clog2(debounce_cycles + 1) - 1:0] count_t;

  // last raw level seen
  logic last_level;
  count_t count;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_level <= 1'b0;
      count <= '0;
      clean <= 1'b0;
    end else if (noisy != last_level) begin
      // any change restarts the stability window
      last_level <= noisy;
      count <= '0;
    end else if (count == count_t'(debounce_cycles)) begin
      // stable for the whole window, pass it on
      clean <= last_level;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/codec_reg_pkg.sv */
`default_nettype none
//////////////////////////////
// codec register definitions
// register map, fixed setup values and command word
//////////////////////////////

package codec_reg_pkg;

  // volume range, 0 is quietest
  typedef logic [4:0] volume_t;
  localparam volume_t volume_max = 5'd31;
  localparam volume_t volume_reset = 5'd8;

  typedef logic [7:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // one register access as carried by slots 1 and 2
  typedef struct packed {
    logic valid;
    reg_addr_t addr;
    reg_data_t data;
  } codec_command_t;

  //////////////////////////////
  // register addresses
  //////////////////////////////

  // msb set selects a read
  localparam reg_addr_t reg_reset_id = 8'h80;
  localparam reg_addr_t reg_headphone = 8'h04;
  localparam reg_addr_t reg_pcm_out = 8'h18;
  localparam reg_addr_t reg_rec_select = 8'h1A;
  localparam reg_addr_t reg_rec_gain = 8'h1C;
  localparam reg_addr_t reg_mic = 8'h0E;
  localparam reg_addr_t reg_beep = 8'h0A;
  localparam reg_addr_t reg_general = 8'h20;

  //////////////////////////////
  // fixed register values
  //////////////////////////////

  // pcm out gain, both channels
  localparam reg_data_t pcm_out_level = 16'h0808;
  // record gain at max on both channels
  localparam reg_data_t rec_gain_max = 16'h0F0F;
  // +20 dB mic boost
  localparam reg_data_t mic_boost = 16'h8048;
  localparam reg_data_t beep_off = 16'h0000;
  // pcm out bypasses mixer 1
  localparam reg_data_t mix_bypass = 16'h8000;
  // record source code for the microphone input
  localparam logic [2:0] source_mic = 3'b000;

  // length of the repeating command list
  localparam int sequence_steps = 16;

endpackage

`default_nettype wire

/* hw/ac97_link_pkg.sv */
`default_nettype none
//////////////////////////////
// ac97 link definitions
// frame layout, slot positions and sample types of the serial link
//////////////////////////////

package ac97_link_pkg;

  //////////////////////////////
  // frame layout
  //////////////////////////////

  // one serial bit per clock, 256 bits per frame
  localparam int frame_bits = 256;

  // bit index within a frame
  typedef logic [7:0] frame_count_t;

  // sync covers the tag slot, bits 0 to 15
  localparam int sync_last_bit = 15;

  // first bit of each 20-bit slot
  localparam int slot1_first = 16;
  localparam int slot2_first = 36;
  localparam int slot3_first = 56;
  localparam int slot4_first = 76;
  // last bit of the right playback slot, everything after is idle
  localparam int slot4_last = 95;
  localparam int slot_width = 20;

  // codec held in reset this many cycles after reset
  localparam int codec_reset_cycles = 1024;

  //////////////////////////////
  // sample types
  //////////////////////////////

  // user side audio sample
  typedef logic [7:0] pcm8_t;

  // full width slot sample, msb first on the wire
  typedef logic [19:0] pcm_slot_t;

  // left and right playback slots, latched together once per frame
  typedef struct packed {
    pcm_slot_t left;
    pcm_slot_t right;
  } playback_pair_t;

endpackage

`default_nettype wire
